/* list.f */
rtl/miss_pkg.sv
rtl/mshr_if.sv
rtl/mshr_entry.sv
rtl/miss_request.sv
rtl/resp_buffer.sv
rtl/refill_engine.sv
rtl/miss_handler.sv
bench/tb_miss_handler.sv

/* run.sh */
#!/bin/sh
# Builds the miss handler testbench with Verilator and runs it
# Exit status is non-zero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f list.f \
    --top-module tb_miss_handler -o tb_miss_handler
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_miss_handler
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0

/* bench/tb_miss_handler.sv */
// Random testbench for the cache miss handler
// Acts as requester, memory and refill arbiter, and checks every DUT output
// each cycle against a cycle model of MSHR, response FIFO and refill state

`timescale 1ns/1ps

module tb_miss_handler;

    localparam int MSHR_ENTRIES = 4;
    localparam int NUM_LINES    = 150;
    localparam int RUN_LIMIT    = 40000;
    localparam int DRAIN_LIMIT  = 4000;

    logic                clk_i;
    logic                rst_ni;
    logic                alloc_i;
    miss_pkg::nline_t    alloc_nline_i;
    miss_pkg::tid_t      alloc_tid_i;
    miss_pkg::word_t     alloc_word_i;
    miss_pkg::way_t      alloc_way_i;
    logic                alloc_need_rsp_i;
    logic                alloc_ready_o;
    miss_pkg::nline_t    check_nline_i;
    logic                check_hit_o;
    logic                mshr_full_o;
    logic                mshr_empty_o;
    logic                mem_req_ready_i;
    logic                mem_req_valid_o;
    miss_pkg::nline_t    mem_req_addr_o;
    miss_pkg::mem_id_t   mem_req_id_o;
    logic                mem_resp_valid_i;
    miss_pkg::mem_id_t   mem_resp_id_i;
    miss_pkg::data_t     mem_resp_data_i;
    logic                mem_resp_last_i;
    logic                mem_resp_error_i;
    logic                mem_resp_ready_o;
    logic                refill_req_ready_i;
    logic                refill_req_valid_o;
    logic                refill_busy_o;
    logic                refill_write_data_o;
    logic                refill_write_dir_o;
    miss_pkg::set_t      refill_set_o;
    miss_pkg::way_t      refill_way_o;
    miss_pkg::word_t     refill_word_o;
    miss_pkg::data_t     refill_data_o;
    miss_pkg::tag_t      refill_tag_o;
    logic                refill_dir_valid_o;
    logic                core_rsp_valid_o;
    miss_pkg::tid_t      core_rsp_tid_o;
    miss_pkg::data_t     core_rsp_data_o;
    logic                core_rsp_error_o;

    // Model state
    logic [31:0]           lfsr_q;
    logic                  ent_busy [MSHR_ENTRIES];
    miss_pkg::mshr_entry_t ent_rec  [MSHR_ENTRIES];
    logic                  send_busy;
    int                    acc_id;
    int                    pend_id [$];
    miss_pkg::nline_t      pend_nline [$];
    logic                  mem_active;
    int                    mem_id_c;
    miss_pkg::nline_t      mem_line;
    int                    mem_beat;
    int                    fq_id [$];
    logic                  fq_err [$];
    logic                  rf_busy;
    miss_pkg::mshr_entry_t rf_rec;
    int                    rf_cnt;
    logic                  rf_err;
    int                    n_alloc;
    int                    n_dir;
    int                    n_rsp;
    logic                  saw_full;
    int                    cyc;

    miss_handler #(.MSHR_ENTRIES(MSHR_ENTRIES)) i_miss_handler (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // Memory contents of word w in line L
    function automatic miss_pkg::data_t mem_word(input miss_pkg::nline_t line, input int w);
        return {line ^ 24'h5ac396, 6'h15, miss_pkg::WORD_W'(w)};
    endfunction

    task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s: expected %0h, actual %0h", name, exp, act);
            $display("TEST FAIL");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s", what);
        $display("TEST FAIL");
        $fatal(1, "Stopped after a timeout");
    endtask

    // Checks at the falling edge, updates the model for the coming rising edge,
    // then drives the next inputs on that edge
    task automatic run_cycle();
        logic                  busy_all;
        logic                  busy_any;
        logic                  hit_exp;
        logic                  err_acc;
        logic                  last;
        logic                  rsp_exp;
        logic                  dup;
        int                    aid;
        int                    gid;
        int                    k;
        int                    idx;
        logic [31:0]           sel;
        miss_pkg::nline_t      line;
        logic                  nx_alloc;
        miss_pkg::mshr_entry_t nx_rec;
        miss_pkg::nline_t      nx_check;
        logic                  nx_req_ready;
        logic                  nx_ref_ready;
        logic                  nx_valid;
        miss_pkg::mem_id_t     nx_id;
        miss_pkg::data_t       nx_data;
        logic                  nx_last;
        logic                  nx_err;

        @(negedge clk_i);
        busy_all = 1'b1;
        busy_any = 1'b0;
        hit_exp  = 1'b0;
        for (int i = 0; i < MSHR_ENTRIES; i++) begin
            busy_all = busy_all & ent_busy[i];
            busy_any = busy_any | ent_busy[i];
            if (ent_busy[i] && ent_rec[i].nline == check_nline_i) begin
                hit_exp = 1'b1;
            end
        end
        if (busy_all) begin
            saw_full = 1'b1;
        end
        check_eq("alloc_ready", 64'(!send_busy && !busy_all), 64'(alloc_ready_o));
        check_eq("mshr_full", 64'(busy_all), 64'(mshr_full_o));
        check_eq("mshr_empty", 64'(!busy_any && !rf_busy), 64'(mshr_empty_o));
        check_eq("check_hit", 64'(hit_exp), 64'(check_hit_o));
        check_eq("mem_req_valid", 64'(send_busy), 64'(mem_req_valid_o));
        check_eq("mem_resp_ready", 64'(fq_id.size() < miss_pkg::RESP_DEPTH),
                 64'(mem_resp_ready_o));
        check_eq("refill_busy", 64'(rf_busy), 64'(refill_busy_o));
        check_eq("refill_req_valid", 64'(!rf_busy && fq_id.size() != 0),
                 64'(refill_req_valid_o));

        // Accepted miss goes to the lowest free entry
        if (alloc_i && alloc_ready_o) begin
            aid = -1;
            for (int i = MSHR_ENTRIES - 1; i >= 0; i--) begin
                if (!ent_busy[i]) begin
                    aid = i;
                end
            end
            ent_busy[aid] = 1'b1;
            ent_rec[aid]  = '{nline: alloc_nline_i, tid: alloc_tid_i, word: alloc_word_i,
                              way: alloc_way_i, need_rsp: alloc_need_rsp_i};
            acc_id    = aid;
            send_busy = 1'b1;
            n_alloc++;
        end

        if (mem_req_valid_o && mem_req_ready_i) begin
            check_eq("mem_req_id", 64'(acc_id), 64'(mem_req_id_o));
            check_eq("mem_req_addr", 64'(ent_rec[acc_id].nline), 64'(mem_req_addr_o));
            pend_id.push_back(acc_id);
            pend_nline.push_back(ent_rec[acc_id].nline);
            send_busy = 1'b0;
        end

        if (rf_busy && fq_id.size() != 0) begin
            err_acc = rf_err | fq_err[0];
            last    = (rf_cnt == miss_pkg::CL_WORDS - 1);
            rsp_exp = rf_rec.need_rsp && (rf_cnt == int'(rf_rec.word));
            check_eq("write_data", 64'(!fq_err[0]), 64'(refill_write_data_o));
            if (!fq_err[0]) begin
                check_eq("write_set", 64'(rf_rec.nline[miss_pkg::SET_W-1:0]), 64'(refill_set_o));
                check_eq("write_way", 64'(rf_rec.way), 64'(refill_way_o));
                check_eq("write_word", 64'(rf_cnt), 64'(refill_word_o));
                check_eq("write_value", 64'(mem_word(rf_rec.nline, rf_cnt)), 64'(refill_data_o));
            end
            check_eq("write_dir", 64'(last), 64'(refill_write_dir_o));
            if (last) begin
                check_eq("dir_tag", 64'(rf_rec.nline[miss_pkg::NLINE_W-1:miss_pkg::SET_W]),
                         64'(refill_tag_o));
                check_eq("dir_set", 64'(rf_rec.nline[miss_pkg::SET_W-1:0]), 64'(refill_set_o));
                check_eq("dir_way", 64'(rf_rec.way), 64'(refill_way_o));
                check_eq("dir_valid", 64'(!err_acc), 64'(refill_dir_valid_o));
                n_dir++;
                rf_busy = 1'b0;
            end
            check_eq("core_rsp_valid", 64'(rsp_exp), 64'(core_rsp_valid_o));
            if (rsp_exp) begin
                check_eq("core_rsp_tid", 64'(rf_rec.tid), 64'(core_rsp_tid_o));
                check_eq("core_rsp_data", 64'(mem_word(rf_rec.nline, rf_cnt)),
                         64'(core_rsp_data_o));
                check_eq("core_rsp_error", 64'(err_acc), 64'(core_rsp_error_o));
                n_rsp++;
            end
            rf_err = err_acc;
            rf_cnt++;
            void'(fq_id.pop_front());
            void'(fq_err.pop_front());
        end else begin
            check_eq("write_data_idle", 64'(0), 64'(refill_write_data_o));
            check_eq("write_dir_idle", 64'(0), 64'(refill_write_dir_o));
            check_eq("core_rsp_idle", 64'(0), 64'(core_rsp_valid_o));
            // Grant takes the entry named by the head beat
            if (!rf_busy && fq_id.size() != 0 && refill_req_ready_i) begin
                gid = fq_id[0];
                rf_rec        = ent_rec[gid];
                ent_busy[gid] = 1'b0;
                rf_busy       = 1'b1;
                rf_cnt        = 0;
                rf_err        = 1'b0;
            end
        end

        if (mem_resp_valid_i && mem_resp_ready_o) begin
            fq_id.push_back(int'(mem_resp_id_i));
            fq_err.push_back(mem_resp_error_i);
            mem_beat++;
            if (mem_beat == miss_pkg::CL_WORDS) begin
                mem_active = 1'b0;
            end
        end

        // Requester holds an unaccepted miss or may start a new one
        nx_alloc = alloc_i;
        nx_rec   = '{nline: alloc_nline_i, tid: alloc_tid_i, word: alloc_word_i,
                     way: alloc_way_i, need_rsp: alloc_need_rsp_i};
        if (!alloc_i || alloc_ready_o) begin
            nx_alloc = 1'b0;
            if (n_alloc < NUM_LINES && rand_bits(1) == 32'd1) begin
                line = miss_pkg::nline_t'(rand_bits(miss_pkg::NLINE_W));
                dup  = rf_busy && (rf_rec.nline == line);
                for (int i = 0; i < MSHR_ENTRIES; i++) begin
                    if (ent_busy[i] && ent_rec[i].nline == line) begin
                        dup = 1'b1;
                    end
                end
                nx_alloc = !dup;
                nx_rec   = '{nline: line,
                             tid: miss_pkg::tid_t'(rand_bits(miss_pkg::TID_W)),
                             word: miss_pkg::word_t'(rand_bits(miss_pkg::WORD_W)),
                             way: miss_pkg::way_t'(rand_bits(miss_pkg::WAY_W)),
                             need_rsp: (rand_bits(2) != 32'd0)};
            end
        end

        // Lookup probe picks a random line, the line in refill or an MSHR line
        sel      = rand_bits(2);
        idx      = int'(rand_bits(2)) % MSHR_ENTRIES;
        nx_check = miss_pkg::nline_t'(rand_bits(miss_pkg::NLINE_W));
        if (sel == 32'd1 && rf_busy) begin
            nx_check = rf_rec.nline;
        end else if (sel != 32'd0 && ent_busy[idx]) begin
            nx_check = ent_rec[idx].nline;
        end

        nx_req_ready = rand_bits(1) == 32'd1;
        nx_ref_ready = rand_bits(1) == 32'd1;

        // Memory returns lines in random order and beats in word order with gaps
        nx_valid = mem_resp_valid_i;
        nx_id    = mem_resp_id_i;
        nx_data  = mem_resp_data_i;
        nx_last  = mem_resp_last_i;
        nx_err   = mem_resp_error_i;
        if (!(mem_resp_valid_i && !mem_resp_ready_o)) begin
            nx_valid = 1'b0;
            if (!mem_active && pend_id.size() != 0 && rand_bits(1) == 32'd1) begin
                k          = int'(rand_bits(8)) % pend_id.size();
                mem_id_c   = pend_id[k];
                mem_line   = pend_nline[k];
                pend_id.delete(k);
                pend_nline.delete(k);
                mem_active = 1'b1;
                mem_beat   = 0;
            end
            if (mem_active && rand_bits(2) != 32'd0) begin
                nx_valid = 1'b1;
                nx_id    = miss_pkg::mem_id_t'(mem_id_c);
                nx_data  = mem_word(mem_line, mem_beat);
                nx_last  = (mem_beat == miss_pkg::CL_WORDS - 1);
                nx_err   = (rand_bits(4) == 32'd0);
            end
        end

        @(posedge clk_i);
        alloc_i            <= nx_alloc;
        alloc_nline_i      <= nx_rec.nline;
        alloc_tid_i        <= nx_rec.tid;
        alloc_word_i       <= nx_rec.word;
        alloc_way_i        <= nx_rec.way;
        alloc_need_rsp_i   <= nx_rec.need_rsp;
        check_nline_i      <= nx_check;
        mem_req_ready_i    <= nx_req_ready;
        refill_req_ready_i <= nx_ref_ready;
        mem_resp_valid_i   <= nx_valid;
        mem_resp_id_i      <= nx_id;
        mem_resp_data_i    <= nx_data;
        mem_resp_last_i    <= nx_last;
        mem_resp_error_i   <= nx_err;
    endtask

    initial begin
        lfsr_q             = 32'h5430;
        rst_ni             = 1'b0;
        alloc_i            = 1'b0;
        alloc_nline_i      = '0;
        alloc_tid_i        = '0;
        alloc_word_i       = '0;
        alloc_way_i        = '0;
        alloc_need_rsp_i   = 1'b0;
        check_nline_i      = '0;
        mem_req_ready_i    = 1'b0;
        mem_resp_valid_i   = 1'b0;
        mem_resp_id_i      = '0;
        mem_resp_data_i    = '0;
        mem_resp_last_i    = 1'b0;
        mem_resp_error_i   = 1'b0;
        refill_req_ready_i = 1'b0;
        for (int i = 0; i < MSHR_ENTRIES; i++) begin
            ent_busy[i] = 1'b0;
        end
        send_busy  = 1'b0;
        mem_active = 1'b0;
        rf_busy    = 1'b0;
        n_alloc    = 0;
        n_dir      = 0;
        n_rsp      = 0;
        saw_full   = 1'b0;

        repeat (8) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_eq("mshr_empty_after_reset", 64'(1), 64'(mshr_empty_o));

        cyc = 0;
        while (n_alloc < NUM_LINES) begin
            if (cyc == RUN_LIMIT) begin
                report_timeout("not all misses were accepted");
            end
            run_cycle();
            cyc++;
        end

        cyc = 0;
        while (n_dir < NUM_LINES) begin
            if (cyc == DRAIN_LIMIT) begin
                report_timeout("outstanding lines were never refilled");
            end
            run_cycle();
            cyc++;
        end

        @(negedge clk_i);
        check_eq("mshr_empty_at_end", 64'(1), 64'(mshr_empty_o));
        check_eq("mshr_full_seen", 64'(1), 64'(saw_full));
        check_eq("core_rsp_seen", 64'(1), 64'(n_rsp != 0));
        $display("TEST PASS");
        $finish;
    end

endmodule

/* rtl/miss_handler.sv */
// Top level of the cache miss handler
// Connects the request unit, the MSHR entry array, the response FIFO
// and the refill engine; MSHR_ENTRIES sets the number of outstanding misses

`timescale 1ns/1ps

module miss_handler #(
    parameter int MSHR_ENTRIES = 4
) (
    input  logic               clk_i,
    input  logic               rst_ni,

    // Miss allocation
    input  logic               alloc_i,
    input  miss_pkg::nline_t   alloc_nline_i,
    input  miss_pkg::tid_t     alloc_tid_i,
    input  miss_pkg::word_t    alloc_word_i,
    input  miss_pkg::way_t     alloc_way_i,
    input  logic               alloc_need_rsp_i,
    output logic               alloc_ready_o,

    // Lookup
    input  miss_pkg::nline_t   check_nline_i,
    output logic               check_hit_o,

    output logic               mshr_full_o,
    output logic               mshr_empty_o,

    // Memory read requests
    input  logic               mem_req_ready_i,
    output logic               mem_req_valid_o,
    output miss_pkg::nline_t   mem_req_addr_o,
    output miss_pkg::mem_id_t  mem_req_id_o,

    // Memory responses
    input  logic               mem_resp_valid_i,
    input  miss_pkg::mem_id_t  mem_resp_id_i,
    input  miss_pkg::data_t    mem_resp_data_i,
    input  logic               mem_resp_last_i,
    input  logic               mem_resp_error_i,
    output logic               mem_resp_ready_o,

    // Cache refill
    input  logic               refill_req_ready_i,
    output logic               refill_req_valid_o,
    output logic               refill_busy_o,
    output logic               refill_write_data_o,
    output logic               refill_write_dir_o,
    output miss_pkg::set_t     refill_set_o,
    output miss_pkg::way_t     refill_way_o,
    output miss_pkg::word_t    refill_word_o,
    output miss_pkg::data_t    refill_data_o,
    output miss_pkg::tag_t     refill_tag_o,
    output logic               refill_dir_valid_o,

    // Core response
    output logic               core_rsp_valid_o,
    output miss_pkg::tid_t     core_rsp_tid_o,
    output miss_pkg::data_t    core_rsp_data_o,
    output logic               core_rsp_error_o
);

    logic                beat_valid;
    logic                beat_pop;
    miss_pkg::mem_beat_t beat;

    mshr_if #(.MSHR_ENTRIES(MSHR_ENTRIES)) i_mshr_if ();

    miss_request #(.MSHR_ENTRIES(MSHR_ENTRIES)) i_miss_request (
        .clk_i, .rst_ni,
        .alloc_i, .alloc_nline_i, .alloc_tid_i, .alloc_word_i, .alloc_way_i,
        .alloc_need_rsp_i, .alloc_ready_o,
        .check_nline_i, .check_hit_o, .mshr_full_o,
        .mem_req_ready_i, .mem_req_valid_o, .mem_req_addr_o, .mem_req_id_o,
        .mshr (i_mshr_if.requester)
    );

    for (genvar i = 0; i < MSHR_ENTRIES; i++) begin : gen_entry
        mshr_entry i_mshr_entry (
            .clk_i, .rst_ni,
            .alloc_i       (i_mshr_if.alloc_en[i]),
            .clear_i       (i_mshr_if.clear_en[i]),
            .alloc_data_i  (i_mshr_if.alloc_data),
            .check_nline_i (i_mshr_if.check_nline),
            .valid_o       (i_mshr_if.valid[i]),
            .match_o       (i_mshr_if.match[i]),
            .entry_o       (i_mshr_if.entries[i])
        );
    end

    resp_buffer i_resp_buffer (
        .clk_i, .rst_ni,
        .mem_resp_valid_i, .mem_resp_id_i, .mem_resp_data_i,
        .mem_resp_last_i, .mem_resp_error_i, .mem_resp_ready_o,
        .pop_i        (beat_pop),
        .beat_valid_o (beat_valid),
        .beat_o       (beat)
    );

    refill_engine #(.MSHR_ENTRIES(MSHR_ENTRIES)) i_refill_engine (
        .clk_i, .rst_ni,
        .beat_valid_i (beat_valid),
        .beat_i       (beat),
        .pop_o        (beat_pop),
        .refill_req_ready_i, .refill_req_valid_o, .refill_busy_o,
        .refill_write_data_o, .refill_write_dir_o,
        .refill_set_o, .refill_way_o, .refill_word_o, .refill_data_o,
        .refill_tag_o, .refill_dir_valid_o,
        .core_rsp_valid_o, .core_rsp_tid_o, .core_rsp_data_o, .core_rsp_error_o,
        .mshr_empty_o,
        .mshr (i_mshr_if.drainer)
    );

endmodule

/* rtl/refill_engine.sv */
// Refill side of the miss handler
// Once the arbiter grants, takes the MSHR entry named by the head beat,
// writes the line word by word, then the directory, and answers the core

`timescale 1ns/1ps

module refill_engine #(
    parameter int MSHR_ENTRIES = 4
) (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  logic                beat_valid_i,
    input  miss_pkg::mem_beat_t beat_i,
    output logic                pop_o,

    input  logic                refill_req_ready_i,
    output logic                refill_req_valid_o,
    output logic                refill_busy_o,

    output logic                refill_write_data_o,
    output logic                refill_write_dir_o,
    output miss_pkg::set_t      refill_set_o,
    output miss_pkg::way_t      refill_way_o,
    output miss_pkg::word_t     refill_word_o,
    output miss_pkg::data_t     refill_data_o,
    output miss_pkg::tag_t      refill_tag_o,
    output logic                refill_dir_valid_o,

    output logic                core_rsp_valid_o,
    output miss_pkg::tid_t      core_rsp_tid_o,
    output miss_pkg::data_t     core_rsp_data_o,
    output logic                core_rsp_error_o,

    output logic                mshr_empty_o,

    mshr_if.drainer             mshr
);

    localparam miss_pkg::word_t LAST_WORD = miss_pkg::WORD_W'(miss_pkg::CL_WORDS - 1);

    miss_pkg::refill_state_e state_q, state_d;
    miss_pkg::mshr_entry_t   ent_q;
    miss_pkg::word_t         cnt_q;
    logic                    err_q;
    logic                    grant;
    logic                    in_write;
    logic                    beat_take;
    logic                    err_acc;
    logic                    last_word;

    assign in_write = (state_q == miss_pkg::REFILL_WRITE);

    // Ask the arbiter only while idle and a beat is waiting
    assign refill_req_valid_o = (state_q == miss_pkg::REFILL_IDLE) && beat_valid_i;
    assign grant              = refill_req_valid_o && refill_req_ready_i;

    // The entry is released at the grant edge
    always_comb begin
        for (int i = 0; i < MSHR_ENTRIES; i++) begin
            mshr.clear_en[i] = grant && (beat_i.id == miss_pkg::mem_id_t'(i));
        end
    end

    assign beat_take = in_write && beat_valid_i;
    assign pop_o     = beat_take;
    assign last_word = (cnt_q == LAST_WORD);

    // Error seen so far on this line, including the current beat
    assign err_acc = err_q | beat_i.error;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            miss_pkg::REFILL_IDLE:  if (grant) state_d = miss_pkg::REFILL_WRITE;
            miss_pkg::REFILL_WRITE: if (beat_take && last_word) state_d = miss_pkg::REFILL_IDLE;
            default:                state_d = miss_pkg::REFILL_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= miss_pkg::REFILL_IDLE;
            cnt_q   <= '0;
            err_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (grant) begin
                cnt_q <= '0;
                err_q <= 1'b0;
            end else if (beat_take) begin
                cnt_q <= cnt_q + 1'b1;
                err_q <= err_acc;
            end
        end
    end

    // Copy of the miss being refilled
    always_ff @(posedge clk_i) begin
        if (grant) begin
            ent_q <= mshr.entries[beat_i.id];
        end
    end

    // Data array and directory writes
    assign refill_write_data_o = beat_take && !beat_i.error;
    assign refill_write_dir_o  = beat_take && last_word;
    assign refill_set_o        = ent_q.nline[miss_pkg::SET_W-1:0];
    assign refill_tag_o        = ent_q.nline[miss_pkg::NLINE_W-1:miss_pkg::SET_W];
    assign refill_way_o        = ent_q.way;
    assign refill_word_o       = cnt_q;
    assign refill_data_o       = beat_i.data;
    assign refill_dir_valid_o  = !err_acc;

    // The core gets the requested word as it passes by
    assign core_rsp_valid_o = beat_take && ent_q.need_rsp && (cnt_q == ent_q.word);
    assign core_rsp_tid_o   = ent_q.tid;
    assign core_rsp_data_o  = beat_i.data;
    assign core_rsp_error_o = err_acc;

    assign refill_busy_o = in_write;

    // Nothing pending and the last refill done
    assign mshr_empty_o = !(|mshr.valid) && !in_write;

endmodule

/* rtl/resp_buffer.sv */
// Circular FIFO for memory response beats
// Memory is stalled through mem_resp_ready_o once all slots are taken

`timescale 1ns/1ps

module resp_buffer (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  logic                mem_resp_valid_i,
    input  miss_pkg::mem_id_t   mem_resp_id_i,
    input  miss_pkg::data_t     mem_resp_data_i,
    input  logic                mem_resp_last_i,
    input  logic                mem_resp_error_i,
    output logic                mem_resp_ready_o,

    input  logic                pop_i,
    output logic                beat_valid_o,
    output miss_pkg::mem_beat_t beat_o
);

    localparam int DEPTH = miss_pkg::RESP_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    miss_pkg::mem_beat_t mem_q [DEPTH];
    logic [PTR_W-1:0]    wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0]    count_q;
    logic                push, pop;

    assign mem_resp_ready_o = (count_q != CNT_W'(DEPTH));
    assign beat_valid_o     = (count_q != '0);

    assign push = mem_resp_valid_i && mem_resp_ready_o;
    assign pop  = pop_i && beat_valid_o;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= '{
                id:    mem_resp_id_i,
                data:  mem_resp_data_i,
                last:  mem_resp_last_i,
                error: mem_resp_error_i
            };
        end
    end

    // Pointers wrap explicitly so any depth works
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    assign beat_o = mem_q[rd_ptr_q];

endmodule

/* rtl/miss_request.sv */
// Request side of the miss handler
// Accepts a new miss, places it in the lowest free MSHR entry and sends
// one line read to memory with the entry index as transaction id

`timescale 1ns/1ps

module miss_request #(
    parameter int MSHR_ENTRIES = 4
) (
    input  logic               clk_i,
    input  logic               rst_ni,

    input  logic               alloc_i,
    input  miss_pkg::nline_t   alloc_nline_i,
    input  miss_pkg::tid_t     alloc_tid_i,
    input  miss_pkg::word_t    alloc_word_i,
    input  miss_pkg::way_t     alloc_way_i,
    input  logic               alloc_need_rsp_i,
    output logic               alloc_ready_o,

    input  miss_pkg::nline_t   check_nline_i,
    output logic               check_hit_o,
    output logic               mshr_full_o,

    input  logic               mem_req_ready_i,
    output logic               mem_req_valid_o,
    output miss_pkg::nline_t   mem_req_addr_o,
    output miss_pkg::mem_id_t  mem_req_id_o,

    mshr_if.requester          mshr
);

    miss_pkg::send_state_e state_q, state_d;
    miss_pkg::nline_t      req_nline_q;
    miss_pkg::mem_id_t     req_id_q;
    miss_pkg::mem_id_t     free_idx;
    logic                  accept;

    assign mshr_full_o   = &mshr.valid;
    assign alloc_ready_o = (state_q == miss_pkg::SEND_IDLE) && !mshr_full_o;
    assign accept        = alloc_i && alloc_ready_o;

    // Lowest-numbered free entry wins
    always_comb begin
        free_idx = '0;
        for (int i = MSHR_ENTRIES - 1; i >= 0; i--) begin
            if (!mshr.valid[i]) begin
                free_idx = miss_pkg::mem_id_t'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < MSHR_ENTRIES; i++) begin
            mshr.alloc_en[i] = accept && (free_idx == miss_pkg::mem_id_t'(i));
        end
    end

    assign mshr.alloc_data = '{
        nline:    alloc_nline_i,
        tid:      alloc_tid_i,
        word:     alloc_word_i,
        way:      alloc_way_i,
        need_rsp: alloc_need_rsp_i
    };

    // Lookup is checked in the same cycle against all entries
    assign mshr.check_nline = check_nline_i;
    assign check_hit_o      = |mshr.match;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            miss_pkg::SEND_IDLE: if (accept) state_d = miss_pkg::SEND_REQ;
            miss_pkg::SEND_REQ:  if (mem_req_ready_i) state_d = miss_pkg::SEND_IDLE;
            default:             state_d = miss_pkg::SEND_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= miss_pkg::SEND_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Memory request payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_nline_q <= alloc_nline_i;
            req_id_q    <= free_idx;
        end
    end

    assign mem_req_valid_o = (state_q == miss_pkg::SEND_REQ);
    assign mem_req_addr_o  = req_nline_q;
    assign mem_req_id_o    = req_id_q;

endmodule

/* rtl/mshr_entry.sv */
// One fully associative MSHR slot
// Holds a pending miss from allocation until the refill engine takes it,
// and compares its line address against the lookup port

`timescale 1ns/1ps

module mshr_entry (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    input  logic                  alloc_i,
    input  logic                  clear_i,
    input  miss_pkg::mshr_entry_t alloc_data_i,

    input  miss_pkg::nline_t      check_nline_i,

    output logic                  valid_o,
    output logic                  match_o,
    output miss_pkg::mshr_entry_t entry_o
);

    logic                  valid_q;
    miss_pkg::mshr_entry_t entry_q;

    // Occupancy flag
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (alloc_i) begin
            valid_q <= 1'b1;
        end else if (clear_i) begin
            valid_q <= 1'b0;
        end
    end

    // Miss record, loaded only when the slot is taken
    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            entry_q <= alloc_data_i;
        end
    end

    assign valid_o = valid_q;
    assign entry_o = entry_q;

    // A free slot never reports a hit, whatever its stale contents
    assign match_o = valid_q && (entry_q.nline == check_nline_i);

endmodule

/* rtl/mshr_if.sv */
// Bundle between the request unit, the MSHR entry array and the refill engine
// The top level ties each entry to its own slice of the vectors

`timescale 1ns/1ps

interface mshr_if #(
    parameter int MSHR_ENTRIES = 4
);

    // Single-cycle one-hot strobes
    logic [MSHR_ENTRIES-1:0]                      alloc_en;
    logic [MSHR_ENTRIES-1:0]                      clear_en;
    miss_pkg::mshr_entry_t                        alloc_data;

    // Entry state seen by both sides
    logic [MSHR_ENTRIES-1:0]                      valid;
    logic [MSHR_ENTRIES-1:0]                      match;
    miss_pkg::mshr_entry_t [MSHR_ENTRIES-1:0]     entries;

    // Line looked up against every entry
    miss_pkg::nline_t                             check_nline;

    modport requester (
        output alloc_en,
        output alloc_data,
        output check_nline,
        input  valid,
        input  match
    );

    modport drainer (
        output clear_en,
        input  valid,
        input  entries
    );

endinterface

/* rtl/miss_pkg.sv */
// Shared widths, records and FSM state types of the cache miss handler
// Every RTL file refers to these by scoped names

package miss_pkg;

    localparam int NLINE_W    = 24;
    localparam int SET_W      = 6;
    localparam int TAG_W      = NLINE_W - SET_W;
    localparam int DATA_W     = 32;
    localparam int CL_WORDS   = 4;
    localparam int WORD_W     = 2;
    localparam int WAY_W      = 2;
    localparam int TID_W      = 4;
    localparam int ID_W       = 3;
    localparam int RESP_DEPTH = 4;

    typedef logic [NLINE_W-1:0] nline_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [SET_W-1:0]   set_t;
    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [WAY_W-1:0]   way_t;
    typedef logic [TID_W-1:0]   tid_t;
    typedef logic [ID_W-1:0]    mem_id_t;

    // One pending miss
    typedef struct packed {
        nline_t nline;
        tid_t   tid;
        word_t  word;
        way_t   way;
        logic   need_rsp;
    } mshr_entry_t;

    // One memory response beat as stored in the response FIFO
    typedef struct packed {
        mem_id_t id;
        data_t   data;
        logic    last;
        logic    error;
    } mem_beat_t;

    typedef enum logic {
        SEND_IDLE,
        SEND_REQ
    } send_state_e;

    typedef enum logic {
        REFILL_IDLE,
        REFILL_WRITE
    } refill_state_e;

endpackage
